// ==== design/match_calc.sv ====
`timescale 1ns/1ps

module match_calc
  import trk_fmt_pkg::*, trk_cfg_pkg::*;
(
  input  logic            clk,
  input  logic            reset,
  input  logic            start,
  input  logic [BX_W-1:0] bx,
  input  cand_t           cand [N_VM],
  input  logic [N_VM-1:0] busy,
  output logic [N_VM-1:0] pop,
  output match_t          match_out,
  output logic            done
);

  logic                    run;
  logic [BX_W-1:0]         bx_lat;
  logic [VM_W-1:0]         last_vm;
  logic [VM_W-1:0]         rr_idx;
  logic [VM_W-1:0]         gnt_vm;
  logic                    gnt;
  logic [N_VM-1:0]         cand_valid;
  cand_t                   gnt_cand;
  logic signed [RES_W-1:0] res;
  logic                    phi_ok;
  logic                    finish;

  always_comb
  begin
    for (int v = 0; v < N_VM; v++)
      cand_valid[v] = cand[v].valid;
  end

  // Search starts one past the engine served last
  always_comb
  begin
    gnt = 1'b0;
    gnt_vm = last_vm;
    rr_idx = last_vm;
    for (int k = 1; k <= N_VM; k++)
    begin
      rr_idx = last_vm + VM_W'(k);
      if (!gnt && cand_valid[rr_idx])
      begin
        gnt = 1'b1;
        gnt_vm = rr_idx;
      end
    end
    pop = '0;
    pop[gnt_vm] = gnt;
  end

  assign gnt_cand = cand[gnt_vm];

  // Stub minus projection
  assign res = $signed({1'b0, gnt_cand.stub_fine}) - $signed({1'b0, gnt_cand.proj_fine});
  assign phi_ok = (res <= PHI_WINDOW) && (res >= -PHI_WINDOW);

  // Everything drained and nothing left in the output register
  assign finish = run && (busy == '0) && (cand_valid == '0) && !match_out.valid;

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      run <= 1'b0;
      done <= 1'b0;
      last_vm <= VM_W'(N_VM - 1);
      match_out <= '0;
    end
    else
    begin
      done <= finish;
      if (finish)
        run <= 1'b0;
      else if (start && !run)
        run <= 1'b1;
      if (gnt)
        last_vm <= gnt_vm;
      match_out.valid <= gnt && phi_ok;
      match_out.bx <= bx_lat;
      match_out.vm <= gnt_vm;
      match_out.id <= gnt_cand.id;
      match_out.stub_idx <= gnt_cand.stub_idx;
      match_out.res <= res;
    end
  end

  always_ff @(posedge clk)
  begin
    if (start && !run)
      bx_lat <= bx;
  end

endmodule

// ==== design/match_chain_top.sv ====
`timescale 1ns/1ps

module match_chain_top
  import trk_fmt_pkg::*, trk_cfg_pkg::*;
(
  input  logic            clk,
  input  logic            reset,
  input  logic            start,
  input  logic [BX_W-1:0] bx,
  input  proj_t           proj_in,
  input  stub_t           stub_in,
  output match_t          match_out,
  output logic            done
);

  logic [N_VM-1:0]  proj_we;
  logic [N_VM-1:0]  stub_we;
  logic [IDX_W-1:0] proj_widx [N_VM];
  logic [IDX_W-1:0] stub_widx [N_VM];
  logic [CNT_W-1:0] proj_cnt [N_VM];
  logic [CNT_W-1:0] stub_cnt [N_VM];
  cand_t            cand [N_VM];
  logic [N_VM-1:0]  busy;
  logic [N_VM-1:0]  pop;

  vm_router vm_router_inst (
    .clk       (clk),
    .reset     (reset),
    .proj_in   (proj_in),
    .stub_in   (stub_in),
    .done      (done),
    .proj_we   (proj_we),
    .stub_we   (stub_we),
    .proj_widx (proj_widx),
    .stub_widx (stub_widx),
    .proj_cnt  (proj_cnt),
    .stub_cnt  (stub_cnt)
  );

  // Data beat goes to every engine, strobes pick the VM
  generate
    for (genvar g = 0; g < N_VM; g++)
    begin : gen_engine
      match_engine match_engine_inst (
        .clk       (clk),
        .reset     (reset),
        .start     (start),
        .proj_in   (proj_in),
        .stub_in   (stub_in),
        .proj_we   (proj_we[g]),
        .stub_we   (stub_we[g]),
        .proj_widx (proj_widx[g]),
        .stub_widx (stub_widx[g]),
        .proj_cnt  (proj_cnt[g]),
        .stub_cnt  (stub_cnt[g]),
        .pop       (pop[g]),
        .cand      (cand[g]),
        .busy      (busy[g])
      );
    end
  endgenerate

  match_calc match_calc_inst (
    .clk       (clk),
    .reset     (reset),
    .start     (start),
    .bx        (bx),
    .cand      (cand),
    .busy      (busy),
    .pop       (pop),
    .match_out (match_out),
    .done      (done)
  );

endmodule

// ==== design/match_engine.sv ====
`timescale 1ns/1ps

module match_engine
  import trk_fmt_pkg::*, trk_cfg_pkg::*;
(
  input  logic             clk,
  input  logic             reset,
  input  logic             start,
  input  proj_t            proj_in,
  input  stub_t            stub_in,
  input  logic             proj_we,
  input  logic             stub_we,
  input  logic [IDX_W-1:0] proj_widx,
  input  logic [IDX_W-1:0] stub_widx,
  input  logic [CNT_W-1:0] proj_cnt,
  input  logic [CNT_W-1:0] stub_cnt,
  input  logic             pop,
  output cand_t            cand,
  output logic             busy
);

  proj_t proj_mem [BUF_DEPTH];
  stub_t stub_mem [BUF_DEPTH];

  logic [CNT_W-1:0] proj_n;
  logic [CNT_W-1:0] stub_n;
  logic [IDX_W-1:0] pi;
  logic [IDX_W-1:0] si;
  logic             walk;
  logic             fresh;
  logic             pair_ok;
  logic             last_proj;
  logic             last_stub;
  logic             stall;

  logic             rd_valid;
  proj_t            proj_rd;
  stub_t            stub_rd;
  logic [IDX_W-1:0] rd_sidx;
  logic signed [Z_W:0] dz;
  logic             z_ok;

  cand_t               fifo_mem [CFIFO_DEPTH];
  cand_t               cand_new;
  logic [CF_PTR_W-1:0] wr_ptr;
  logic [CF_PTR_W-1:0] rd_ptr;
  logic [CF_PTR_W:0]   fifo_cnt;
  logic                push;
  logic                pull;

  always_ff @(posedge clk)
  begin
    if (proj_we)
      proj_mem[proj_widx] <= proj_in;
    if (stub_we)
      stub_mem[stub_widx] <= stub_in;
  end

  // Entries written since the engine last launched
  always_ff @(posedge clk)
  begin
    if (reset)
      fresh <= 1'b0;
    else if (proj_we || stub_we)
      fresh <= 1'b1;
    else if (start && !busy)
      fresh <= 1'b0;
  end

  assign pair_ok = (proj_n != '0) && (stub_n != '0);
  assign last_stub = ({1'b0, si} == stub_n - 1'b1);
  assign last_proj = ({1'b0, pi} == proj_n - 1'b1);
  assign stall = (fifo_cnt == (CF_PTR_W + 1)'(CFIFO_DEPTH));

  // Stub index runs inner and projection index outer
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      walk <= 1'b0;
      pi <= '0;
      si <= '0;
      proj_n <= '0;
      stub_n <= '0;
    end
    else if (start && !busy)
    begin
      walk <= 1'b1;
      pi <= '0;
      si <= '0;
      // A start with nothing new loaded walks an empty buffer
      proj_n <= fresh ? proj_cnt : '0;
      stub_n <= fresh ? stub_cnt : '0;
    end
    else if (walk && !stall)
    begin
      if (!pair_ok)
        walk <= 1'b0;
      else if (last_stub)
      begin
        si <= '0;
        if (last_proj)
          walk <= 1'b0;
        else
          pi <= pi + 1'b1;
      end
      else
        si <= si + 1'b1;
    end
  end

  // Registered read stage is frozen while the FIFO is full
  always_ff @(posedge clk)
  begin
    if (reset)
      rd_valid <= 1'b0;
    else if (!stall)
      rd_valid <= walk && pair_ok;
  end

  always_ff @(posedge clk)
  begin
    if (!stall)
    begin
      proj_rd <= proj_mem[pi];
      stub_rd <= stub_mem[si];
      rd_sidx <= si;
    end
  end

  assign dz = $signed({1'b0, proj_rd.z}) - $signed({1'b0, stub_rd.z});
  assign z_ok = (dz <= Z_WINDOW) && (dz >= -Z_WINDOW);

  assign push = rd_valid && z_ok && !stall;
  assign pull = pop && cand.valid;

  always_comb
  begin
    cand_new.valid = 1'b1;
    cand_new.id = proj_rd.id;
    cand_new.stub_idx = rd_sidx;
    cand_new.proj_fine = proj_rd.phi[FINE_W-1:0];
    cand_new.stub_fine = stub_rd.phi[FINE_W-1:0];
  end

  always_ff @(posedge clk)
  begin
    if (push)
      fifo_mem[wr_ptr] <= cand_new;
  end

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      fifo_cnt <= '0;
    end
    else
    begin
      if (push)
        wr_ptr <= wr_ptr + 1'b1;
      if (pull)
        rd_ptr <= rd_ptr + 1'b1;
      case ({push, pull})
        2'b10: fifo_cnt <= fifo_cnt + 1'b1;
        2'b01: fifo_cnt <= fifo_cnt - 1'b1;
        default: fifo_cnt <= fifo_cnt;
      endcase
    end
  end

  // Head of FIFO
  always_comb
  begin
    cand = fifo_mem[rd_ptr];
    cand.valid = (fifo_cnt != '0);
  end

  assign busy = walk || rd_valid || (fifo_cnt != '0);

endmodule

// ==== design/trk_cfg_pkg.sv ====
package trk_cfg_pkg;

  // Virtual modules, one match engine each
  localparam int N_VM = 8;
  localparam int VM_W = $clog2(N_VM);

  // Per-VM buffers
  localparam int BUF_DEPTH = 16;
  localparam int IDX_W = $clog2(BUF_DEPTH);
  // Count reaches BUF_DEPTH, so one bit wider than an index
  localparam int CNT_W = IDX_W + 1;

  // Low bits of phi used by the residual cut
  localparam int FINE_W = 5;

  // Matching windows
  localparam int Z_WINDOW = 2;
  localparam int PHI_WINDOW = 3;

  // Candidate FIFO between engine and calculator
  localparam int CFIFO_DEPTH = 4;
  localparam int CF_PTR_W = $clog2(CFIFO_DEPTH);

endpackage

// ==== design/trk_fmt_pkg.sv ====
package trk_fmt_pkg;

  import trk_cfg_pkg::*;

  localparam int PHI_W = 8;
  localparam int Z_W = 8;
  localparam int PROJ_ID_W = 6;
  localparam int BX_W = 3;
  // Signed difference of two fine phi values
  localparam int RES_W = FINE_W + 1;

  // Top VM_W bits of phi select the virtual module
  typedef struct packed {
    logic                 valid;
    logic [PHI_W-1:0]     phi;
    logic [Z_W-1:0]       z;
    logic [PROJ_ID_W-1:0] id;
  } proj_t;

  typedef struct packed {
    logic             valid;
    logic [PHI_W-1:0] phi;
    logic [Z_W-1:0]   z;
  } stub_t;

  // Pair that passed the z cut, waiting for the phi residual cut
  typedef struct packed {
    logic                 valid;
    logic [PROJ_ID_W-1:0] id;
    logic [IDX_W-1:0]     stub_idx;
    logic [FINE_W-1:0]    proj_fine;
    logic [FINE_W-1:0]    stub_fine;
  } cand_t;

  typedef struct packed {
    logic                    valid;
    logic [BX_W-1:0]         bx;
    logic [VM_W-1:0]         vm;
    logic [PROJ_ID_W-1:0]    id;
    logic [IDX_W-1:0]        stub_idx;
    logic signed [RES_W-1:0] res;
  } match_t;

endpackage

// ==== design/vm_router.sv ====
`timescale 1ns/1ps

module vm_router
  import trk_fmt_pkg::*, trk_cfg_pkg::*;
(
  input  logic             clk,
  input  logic             reset,
  input  proj_t            proj_in,
  input  stub_t            stub_in,
  input  logic             done,
  output logic [N_VM-1:0]  proj_we,
  output logic [N_VM-1:0]  stub_we,
  output logic [IDX_W-1:0] proj_widx [N_VM],
  output logic [IDX_W-1:0] stub_widx [N_VM],
  output logic [CNT_W-1:0] proj_cnt [N_VM],
  output logic [CNT_W-1:0] stub_cnt [N_VM]
);

  logic [VM_W-1:0] proj_vm;
  logic [VM_W-1:0] stub_vm;

  // Coarse phi picks the VM
  assign proj_vm = proj_in.phi[PHI_W-1 -: VM_W];
  assign stub_vm = stub_in.phi[PHI_W-1 -: VM_W];

  // Next free slot is the current count, full buffers drop the beat
  always_comb
  begin
    for (int v = 0; v < N_VM; v++)
    begin
      proj_we[v] = proj_in.valid && (proj_vm == VM_W'(v)) && (proj_cnt[v] < BUF_DEPTH);
      stub_we[v] = stub_in.valid && (stub_vm == VM_W'(v)) && (stub_cnt[v] < BUF_DEPTH);
      proj_widx[v] = proj_cnt[v][IDX_W-1:0];
      stub_widx[v] = stub_cnt[v][IDX_W-1:0];
    end
  end

  always_ff @(posedge clk)
  begin
    if (reset || done)
    begin
      for (int v = 0; v < N_VM; v++)
      begin
        proj_cnt[v] <= '0;
        stub_cnt[v] <= '0;
      end
    end
    else
    begin
      for (int v = 0; v < N_VM; v++)
      begin
        if (proj_we[v])
          proj_cnt[v] <= proj_cnt[v] + 1'b1;
        if (stub_we[v])
          stub_cnt[v] <= stub_cnt[v] + 1'b1;
      end
    end
  end

endmodule

// ==== dv/match_chain_sva.sv ====
`timescale 1ns/1ps

module match_chain_sva
  import trk_fmt_pkg::*, trk_cfg_pkg::*;
(
  input logic            clk,
  input logic            reset,
  input logic            start,
  input logic [BX_W-1:0] bx,
  input match_t          match_out,
  input logic            done
);

  int              fail_count = 0;
  logic            started;
  logic            active;
  logic            accept;
  logic [BX_W-1:0] bx_lat;

  // Same acceptance rule as the calculator's run flag
  assign accept = start && !(active && !done);

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      started <= 1'b0;
      active <= 1'b0;
    end
    else
    begin
      started <= started || start;
      if (accept)
        active <= 1'b1;
      else if (done)
        active <= 1'b0;
    end
  end

  always_ff @(posedge clk)
  begin
    if (accept)
      bx_lat <= bx;
  end

  a_quiet: assert property (@(posedge clk) disable iff (reset)
    !started |-> !done && !match_out.valid)
  else
  begin
    $error("done or a match came out before the first start");
    fail_count++;
  end

  a_done_pulse: assert property (@(posedge clk) disable iff (reset)
    done |-> !$past(done) && !$past(accept) && !$past(accept, 2))
  else
  begin
    $error("done was longer than one cycle or came too soon after start");
    fail_count++;
  end

  a_match_window: assert property (@(posedge clk) disable iff (reset)
    match_out.valid |-> active && !done)
  else
  begin
    $error("a match came out while no run was active");
    fail_count++;
  end

  a_match_fields: assert property (@(posedge clk) disable iff (reset)
    match_out.valid |-> match_out.bx == bx_lat &&
      $signed(match_out.res) <= PHI_WINDOW && $signed(match_out.res) >= -PHI_WINDOW)
  else
  begin
    $error("a match had the wrong bx or a residual outside the phi window");
    fail_count++;
  end

endmodule

bind match_chain_top match_chain_sva match_chain_sva_inst (
  .clk       (clk),
  .reset     (reset),
  .start     (start),
  .bx        (bx),
  .match_out (match_out),
  .done      (done)
);

// ==== dv/match_chain_tb.sv ====
`timescale 1ns/1ps

module match_chain_tb
  import trk_fmt_pkg::*, trk_cfg_pkg::*;
();

  localparam int RUNS = 5;
  localparam int LOAD_MAX = 64;
  localparam int CYCLE_LIMIT = RUNS * (N_VM * BUF_DEPTH * BUF_DEPTH + LOAD_MAX) + 200;

  logic            clk;
  logic            reset;
  logic            start;
  logic [BX_W-1:0] bx;
  proj_t           proj_in;
  stub_t           stub_in;
  match_t          match_out;
  logic            done;

  // Reference copy of every VM buffer
  proj_t           mp [N_VM][BUF_DEPTH];
  stub_t           ms [N_VM][BUF_DEPTH];
  int              mpc [N_VM];
  int              msc [N_VM];
  logic [31:0]     exp_q [$];
  int              got = 0;
  int              errors = 0;
  int              done_cnt = 0;
  int              cycles = 0;
  logic [BX_W-1:0] run_bx;
  logic [31:0]     rng = 32'haae4f744;

  match_chain_top match_chain_top_inst (
    .clk       (clk),
    .reset     (reset),
    .start     (start),
    .bx        (bx),
    .proj_in   (proj_in),
    .stub_in   (stub_in),
    .match_out (match_out),
    .done      (done)
  );

  initial
  begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic [31:0] match_key(input logic [VM_W-1:0] vm,
      input logic [PROJ_ID_W-1:0] id, input logic [IDX_W-1:0] sidx,
      input logic [RES_W-1:0] res);
    return {13'd0, vm, id, sidx, res};
  endfunction

  task automatic check(input bit ok, input string msg);
    assert (ok)
    else
    begin
      $display("[FAIL] %0t: %s", $time, msg);
      errors++;
    end
  endtask

  // vm below zero spreads beats over all VMs, same makes every pair match
  task automatic load_beats(input int vm, input int beats, input bit same);
    logic [31:0] r;
    proj_t       p;
    stub_t       s;
    int          pv;
    int          sv;
    for (int i = 0; i < beats; i++)
    begin
      rng = xorshift(rng);
      r = rng;
      p = '{1'b1, r[7:0], 8'(100 + r[11:8]), r[17:12]};
      s = '{r[31], r[25:18], 8'(100 + r[29:26])};
      if (vm >= 0)
      begin
        p.phi[PHI_W-1 -: VM_W] = VM_W'(vm);
        s.phi[PHI_W-1 -: VM_W] = VM_W'(vm);
        s.valid = 1'b1;
      end
      if (same)
      begin
        p = '{1'b1, {VM_W'(vm), FINE_W'(10)}, 8'd50, PROJ_ID_W'(vm * 8 + i)};
        s = '{1'b1, {VM_W'(vm), FINE_W'(12)}, 8'd51};
      end
      pv = int'(p.phi[PHI_W-1 -: VM_W]);
      sv = int'(s.phi[PHI_W-1 -: VM_W]);
      // Beats beyond the buffer depth are dropped
      if (mpc[pv] < BUF_DEPTH)
      begin
        mp[pv][mpc[pv]] = p;
        mpc[pv]++;
      end
      if (s.valid && msc[sv] < BUF_DEPTH)
      begin
        ms[sv][msc[sv]] = s;
        msc[sv]++;
      end
      @(posedge clk);
      proj_in <= p;
      stub_in <= s;
    end
  endtask

  task automatic launch_run(input logic [BX_W-1:0] run_bx_in, input bit restart);
    int exp_total;
    int got_before;
    int done_before;
    int dz;
    int res;
    exp_q.delete();
    for (int v = 0; v < N_VM; v++)
      for (int p = 0; p < mpc[v]; p++)
        for (int s = 0; s < msc[v]; s++)
        begin
          dz = int'(mp[v][p].z) - int'(ms[v][s].z);
          res = int'(ms[v][s].phi[FINE_W-1:0]) - int'(mp[v][p].phi[FINE_W-1:0]);
          if (dz >= -Z_WINDOW && dz <= Z_WINDOW && res >= -PHI_WINDOW && res <= PHI_WINDOW)
            exp_q.push_back(match_key(VM_W'(v), mp[v][p].id, IDX_W'(s), RES_W'(res)));
        end
    exp_total = exp_q.size();
    got_before = got;
    done_before = done_cnt;
    run_bx = run_bx_in;
    @(posedge clk);
    proj_in <= '0;
    stub_in <= '0;
    start <= 1'b1;
    bx <= run_bx_in;
    @(posedge clk);
    start <= 1'b0;
    bx <= ~run_bx_in;
    // Start while busy, must not relaunch or relatch bx
    if (restart)
    begin
      repeat (3) @(posedge clk);
      start <= 1'b1;
      @(posedge clk);
      start <= 1'b0;
    end
    @(negedge clk);
    while (!done)
      @(negedge clk);
    repeat (3) @(negedge clk);
    check(got - got_before == exp_total,
      $sformatf("run bx %0d gave %0d matches, expected %0d", run_bx, got - got_before, exp_total));
    check(exp_q.size() == 0, $sformatf("%0d expected matches never arrived", exp_q.size()));
    check(done_cnt == done_before + 1,
      $sformatf("done pulsed %0d times in one run", done_cnt - done_before));
    for (int v = 0; v < N_VM; v++)
    begin
      mpc[v] = 0;
      msc[v] = 0;
    end
  endtask

  task automatic check_match();
    logic [31:0] key;
    int          hit;
    key = match_key(match_out.vm, match_out.id, match_out.stub_idx, match_out.res);
    hit = -1;
    foreach (exp_q[i])
      if (hit < 0 && exp_q[i] == key)
        hit = i;
    check(hit >= 0, $sformatf("unexpected match vm %0d id %0d stub %0d res %0d",
      match_out.vm, match_out.id, match_out.stub_idx, $signed(match_out.res)));
    if (hit >= 0)
      exp_q.delete(hit);
    got++;
    check(match_out.bx == run_bx, $sformatf("match bx %0d, expected %0d", match_out.bx, run_bx));
    check($signed(match_out.res) >= -PHI_WINDOW && $signed(match_out.res) <= PHI_WINDOW,
      $sformatf("match residual %0d outside the phi window", $signed(match_out.res)));
  endtask

  always @(negedge clk)
  begin
    if (!reset && match_out.valid)
      check_match();
    if (!reset && done)
      done_cnt++;
  end

  always @(posedge clk)
  begin
    cycles++;
    if (cycles > CYCLE_LIMIT)
    begin
      $display("Timeout after %0d cycles, the last run never finished", CYCLE_LIMIT);
      $display("TESTS FAILED");
      $finish;
    end
  end

  initial
  begin
    int sva_fails;
    reset = 1'b1;
    start = 1'b0;
    bx = '0;
    proj_in = '0;
    stub_in = '0;
    repeat (2) @(posedge clk);
    reset <= 1'b0;
    repeat (5) @(posedge clk);
    load_beats(-1, 32, 1'b0);
    launch_run(3'd5, 1'b1);
    // Fresh counts after done
    load_beats(-1, 32, 1'b0);
    launch_run(3'd2, 1'b0);
    // One VM loaded past its depth, the others empty
    load_beats(5, 20, 1'b0);
    launch_run(3'd7, 1'b0);
    // Every pair matches, candidate FIFOs back up
    for (int v = 0; v < N_VM; v++)
      load_beats(v, 6, 1'b1);
    launch_run(3'd1, 1'b0);
    load_beats(-1, 40, 1'b0);
    launch_run(3'd6, 1'b0);
    sva_fails = match_chain_top_inst.match_chain_sva_inst.fail_count;
    $display("Errors: %0d testbench, %0d assertion", errors, sva_fails);
    if (errors == 0 && sva_fails == 0)
      $display("TESTS PASSED");
    else
      $display("TESTS FAILED");
    $finish;
  end

endmodule

// ==== match_chain_top.f ====
design/trk_cfg_pkg.sv
design/trk_fmt_pkg.sv
design/vm_router.sv
design/match_engine.sv
design/match_calc.sv
design/match_chain_top.sv
dv/match_chain_sva.sv
dv/match_chain_tb.sv

// ==== run.sh ====
#!/bin/sh
# Verilator build and run of match_chain_tb
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module match_chain_tb \
  -f match_chain_top.f -o match_chain_sim || exit 1
out=$(./obj_dir/match_chain_sim +verilator+error+limit+100)
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -qx "TESTS PASSED" && exit 0 || exit 1
